// ==== lane_init_top.f ====
+incdir+verilog
verilog/lane_init_pkg.sv
verilog/cable_prop_reader.sv
verilog/param_exchange.sv
verilog/os_counter.sv
verilog/lane_init_fsm.sv
verilog/lane_init_top.sv
sim/lane_init_checker.sv
sim/lane_init_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the lane initialization testbench with Verilator

LOG=sim.log

verilator --binary --timing --assert -j 0 -f lane_init_top.f \
  --top-module lane_init_tb -Mdir obj_dir -o lane_init_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/lane_init_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "STATUS: FAIL" "$LOG"; then
  exit 1
fi
exit 0

// ==== sim/lane_init_checker.sv ====
`default_nettype none

module lane_init_checker
  import lane_init_pkg::*;
(
  input  wire              fsm_clk,
  input  wire              reset_n,
  input  wire              lane_disable_i,
  input  wire              disconnect_rx_i,
  input  wire              training_timeout_i,
  input  wire              os_sent_i,
  input  wire              sync_busy_i,
  input  wire at_rsp_t     at_rsp_i,
  input  wire [31:0]       cfg_data_i,
  input  wire os_sel_e     os_sel_i,
  input  wire link_gen_e   gen_speed_i,
  input  wire              disabled_i,
  input  wire              training_i,
  input  wire              cl0_i,
  input  wire              sbtx_idle_i,
  input  wire              at_req_i,
  input  wire              cfg_rd_i,
  input  wire [7:0]        cfg_addr_i,
  output int               err_cnt_o,
  output int               chk_cnt_o
);
  timeunit 1ns;
  timeprecision 1ps;

  logic [31:0] cfg_word;
  logic [23:0] good_payload;
  logic        cfg_rd_d, started, prev_training, cable_bad;
  logic        chk_dis, chk_disc, chk_tmo, want_req;
  logic        prop_q, first_prop;
  os_sel_e     prev_os;
  logic [19:0] seq;
  int          seq_idx, sent_seen, reqs_since_rsp, req_wait;

  ////////////////////////////////////////////////////////////////////////////
  // reference rules

  // slower of cable and partner generation
  function automatic link_gen_e expected_gen(input logic [31:0] cfg, input logic [23:0] pl);
    if (!(cfg[21] || cfg[20]) || !(pl[18] || pl[13]))
      return GEN2;
    if (!cfg[21] || !pl[18])
      return GEN3;
    return GEN4;
  endfunction

  // opcode order, first phase in the low nibble
  function automatic logic [19:0] expected_sequence(input link_gen_e gen);
    if (gen == GEN4)
      return {4'd8, 4'd7, 4'd6, 4'd5, 4'd4};
    return {4'd8, 4'd3, 4'd2, 4'd1, 4'd0};
  endfunction

  function automatic int sent_target(input os_sel_e op, input link_gen_e gen);
    case (op)
      OS_SLOS1, OS_SLOS2: return 2;
      OS_G23_TS1:         return (gen == GEN2) ? 32 : 16;
      OS_G23_TS2:         return (gen == GEN2) ? 16 : 8;
      default:            return 16;    // all four Gen4 phases
    endcase
  endfunction

  task automatic check(input string name, input logic [31:0] exp, input logic [31:0] got);
    chk_cnt_o++;
    if (exp !== got)
    begin
      err_cnt_o++;
      $display("[ERROR] %s expected %h got %h at %0t", name, exp, got, $time);
    end
  endtask

  task automatic fail(input string what);
    err_cnt_o++;
    $display("[ERROR] %s at %0t", what, $time);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // comparison process

  always @(posedge fsm_clk)
  begin
    if (!reset_n)
    begin
      err_cnt_o = 0;
      chk_cnt_o = 0;
      started = 0;
      cfg_rd_d = 0;
      cable_bad = 0;
      prev_training = 0;
      chk_dis = 0;
      chk_disc = 0;
      chk_tmo = 0;
      want_req = 0;
      req_wait = 0;
      reqs_since_rsp = 0;
      seq_idx = 0;
      sent_seen = 0;
      prev_os = OS_ZEROS;
      prop_q = 0;
      first_prop = 0;
      cfg_word = '0;
      good_payload = '0;
    end
    else
    begin
      if (!started)
      begin
        check("disabled_o", 32'd1, 32'(disabled_i));
        check("sbtx_idle_o", 32'd1, 32'(sbtx_idle_i));
        check("training_o", 32'd0, 32'(training_i));
        check("cl0_o", 32'd0, 32'(cl0_i));
        check("at_req_o", 32'd0, 32'(at_req_i));
        check("cfg_rd_o", 32'd0, 32'(cfg_rd_i));
        check("os_sel_o", 32'(OS_ZEROS), 32'(os_sel_i));
        started = 1;
      end
      if (at_req_i && sync_busy_i)
        fail("at_req_o pulsed while sync_busy_i was high");

      // effects of last cycle's events
      if (chk_dis)
        check("disabled_o", 32'd1, 32'(disabled_i));
      if (chk_disc)
      begin
        check("cl0_o", 32'd0, 32'(cl0_i));
        check("os_sel_o", 32'(OS_ZEROS), 32'(os_sel_i));
        check("sbtx_idle_o", 32'd0, 32'(sbtx_idle_i));
      end
      if (chk_tmo)
        check("training_o", 32'd0, 32'(training_i));
      chk_dis  = lane_disable_i;
      chk_disc = cl0_i && disconnect_rx_i && !lane_disable_i;
      chk_tmo  = training_timeout_i && training_i && !lane_disable_i && !disconnect_rx_i;
      if (chk_tmo)
      begin
        want_req = 1;
        req_wait = 0;
      end

      // one request per response, entry and retries alike
      if (disabled_i)
        reqs_since_rsp = 0;
      if (at_req_i)
      begin
        reqs_since_rsp++;
        want_req = 0;
      end
      if (want_req && ++req_wait > 300)
      begin
        fail("no at_req_o pulse followed the training timeout");
        want_req = 0;
      end
      if (at_rsp_i.valid)
      begin
        check("at_req_o pulses per response", 32'd1, 32'(reqs_since_rsp));
        reqs_since_rsp = 0;
        if (!at_rsp_i.error)
          good_payload = at_rsp_i.payload;
      end

      // cable word is on the bus the cycle after the strobe
      if (cfg_rd_d)
      begin
        cfg_word  = cfg_data_i;
        cable_bad = (cfg_data_i[7:0] != 8'h40);
      end
      cfg_rd_d = cfg_rd_i;
      if (cable_bad)
      begin
        check("sbtx_idle_o", 32'd1, 32'(sbtx_idle_i));
        check("training_o", 32'd0, 32'(training_i));
      end

      // strobe and address only on the first cycle of the cable property read
      first_prop = sbtx_idle_i && !disabled_i && !prop_q;
      check("cfg_rd_o", 32'(first_prop), 32'(cfg_rd_i));
      check("cfg_addr_o", first_prop ? 32'd18 : 32'd0, 32'(cfg_addr_i));
      prop_q = sbtx_idle_i && !disabled_i;

      if (training_i && !prev_training)
        check("gen_speed_o", 32'(expected_gen(cfg_word, good_payload)), 32'(gen_speed_i));
      prev_training = training_i;

      if (os_sel_i != prev_os)
      begin
        if (os_sel_i == OS_ZEROS)
          seq_idx = 0;
        else
        begin
          if (prev_os != OS_ZEROS && prev_os != OS_DATA &&
              sent_seen < sent_target(prev_os, gen_speed_i))
            fail($sformatf("phase %0d ended after only %0d sets sent", prev_os, sent_seen));
          seq = expected_sequence(gen_speed_i);
          if (seq_idx > 4)
            fail("os_sel_o moved past CL0 data");
          else
            check("os_sel_o", 32'(seq[seq_idx*4 +: 4]), 32'(os_sel_i));
          seq_idx++;
        end
        sent_seen = 0;
      end
      if (os_sent_i)
        sent_seen++;
      prev_os = os_sel_i;
    end
  end

endmodule

`default_nettype wire

// ==== sim/lane_init_tb.sv ====
`default_nettype none

module lane_init_tb
  import lane_init_pkg::*;
();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int CYCLE_LIMIT = 6000;   // ~6 scenarios of up to 800 cycles plus margin

  logic        fsm_clk, reset_n;
  logic        lane_disable_i, disabled_min_i, disconnect_rx_i, training_timeout_i;
  logic        new_sym_i, os_sent_i, sync_busy_i;
  os_rx_t      os_rx_i;
  at_rsp_t     at_rsp_i;
  logic [31:0] cfg_data_i;
  os_sel_e     os_sel_o;
  link_gen_e   gen_speed_o;
  logic        disabled_o, training_o, cl0_o, sbtx_idle_o, at_req_o, cfg_rd_o;
  logic [7:0]  cfg_addr_o;
  int          err_cnt, chk_cnt, tb_fail, cycles;
  int          seed, gap_seed;

  lane_init_top dut0 (
    .fsm_clk(fsm_clk), .reset_n(reset_n), .lane_disable_i(lane_disable_i),
    .disabled_min_i(disabled_min_i), .disconnect_rx_i(disconnect_rx_i),
    .training_timeout_i(training_timeout_i), .new_sym_i(new_sym_i),
    .os_sent_i(os_sent_i), .os_rx_i(os_rx_i), .at_rsp_i(at_rsp_i),
    .sync_busy_i(sync_busy_i), .cfg_data_i(cfg_data_i), .os_sel_o(os_sel_o),
    .gen_speed_o(gen_speed_o), .disabled_o(disabled_o), .training_o(training_o),
    .cl0_o(cl0_o), .sbtx_idle_o(sbtx_idle_o), .at_req_o(at_req_o),
    .cfg_rd_o(cfg_rd_o), .cfg_addr_o(cfg_addr_o)
  );

  lane_init_checker chk0 (
    .fsm_clk(fsm_clk), .reset_n(reset_n), .lane_disable_i(lane_disable_i),
    .disconnect_rx_i(disconnect_rx_i), .training_timeout_i(training_timeout_i),
    .os_sent_i(os_sent_i), .sync_busy_i(sync_busy_i), .at_rsp_i(at_rsp_i),
    .cfg_data_i(cfg_data_i), .os_sel_i(os_sel_o), .gen_speed_i(gen_speed_o),
    .disabled_i(disabled_o), .training_i(training_o), .cl0_i(cl0_o),
    .sbtx_idle_i(sbtx_idle_o), .at_req_i(at_req_o), .cfg_rd_i(cfg_rd_o),
    .cfg_addr_i(cfg_addr_o), .err_cnt_o(err_cnt), .chk_cnt_o(chk_cnt)
  );

  initial
  begin
    fsm_clk = 1'b0;
    forever #5 fsm_clk = ~fsm_clk;
  end

  always @(posedge fsm_clk)
  begin
    cycles++;
    if (cycles >= CYCLE_LIMIT)
    begin
      $display("simulation stopped after %0d cycles without finishing", cycles);
      $display("STATUS: FAIL");
      $finish;
    end
  end

  // link partner echoes the lanes and paces sent sets and symbols
  always @(negedge fsm_clk)
  begin
    os_rx_i.lane0 = os_sel_o;
    os_rx_i.lane1 = os_sel_o;
    os_sent_i     = ($random(seed) & 3) != 0;
    new_sym_i     = ($random(seed) & 3) == 0;
  end

  ////////////////////////////////////////////////////////////////////////////
  // helpers

  task automatic step(input int n);
    repeat (n) @(negedge fsm_clk);
  endtask

  function automatic logic probe(input int sel);
    case (sel)
      0:       return at_req_o;
      1:       return cl0_o;
      2:       return training_o;
      default: return !sbtx_idle_o;
    endcase
  endfunction

  // sampled on the rising edge, returns on the next falling edge
  task automatic wait_for(input int sel, input string what);
    int n;
    n = 0;
    @(posedge fsm_clk);
    while (!probe(sel) && n < 1000)
    begin
      @(posedge fsm_clk);
      n++;
    end
    @(negedge fsm_clk);
    if (n >= 1000)
    begin
      $display("timed out waiting for %s", what);
      tb_fail++;
    end
  endtask

  task automatic answer_params(input logic [23:0] payload, input int n_err);
    for (int i = 0; i <= n_err; i++)
    begin
      wait_for(0, "at_req_o");
      step(1 + ($random(gap_seed) & 3));
      at_rsp_i = '{valid: 1'b1, error: (i < n_err), payload: payload};
      if (i < n_err)
        sync_busy_i = 1'b1;   // retry must wait for the synchronizer
      step(1);
      at_rsp_i = '0;
      step(3);
      sync_busy_i = 1'b0;
    end
  endtask

  task automatic bring_up(input logic [31:0] cfg, input logic [23:0] payload, input int n_err);
    sync_busy_i    = 1'b1;
    lane_disable_i = 1'b1;
    disabled_min_i = 1'b1;
    cfg_data_i     = cfg;
    step(1);
    lane_disable_i = 1'b0;
    wait_for(3, "exit from cable property read");
    step(3);
    sync_busy_i = 1'b0;
    answer_params(payload, n_err);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // scenarios

  initial
  begin
    seed = 51271;
    gap_seed = seed ^ 32'h5a5a;
    cycles = 0;
    tb_fail = 0;
    reset_n = 1'b0;
    lane_disable_i = 0;
    disabled_min_i = 0;
    disconnect_rx_i = 0;
    training_timeout_i = 0;
    new_sym_i = 0;
    os_sent_i = 0;
    sync_busy_i = 0;
    os_rx_i = '{lane0: OS_ZEROS, lane1: OS_ZEROS};
    at_rsp_i = '0;
    cfg_data_i = '0;
    step(2);
    reset_n = 1'b1;
    step(2);

    bring_up(32'h0020_0040, 24'h04_0000, 0);     // gen4 cable, gen4 partner
    wait_for(1, "cl0_o");
    step(3);
    disconnect_rx_i = 1'b1;
    step(1);
    disconnect_rx_i = 1'b0;
    step(5);
    bring_up(32'h0020_0040, 24'h00_2000, 0);     // gen3 partner
    wait_for(1, "cl0_o");
    bring_up(32'h0000_0040, 24'h04_0000, 0);     // gen2 cable
    wait_for(1, "cl0_o");
    bring_up(32'h0010_0040, 24'h04_0000, 2);     // two errored responses
    wait_for(1, "cl0_o");

    lane_disable_i = 1'b1;                       // cable without usb4 id
    cfg_data_i = 32'h0020_0041;
    step(1);
    lane_disable_i = 1'b0;
    step(100);

    bring_up(32'h0020_0040, 24'h00_2000, 0);
    wait_for(2, "training_o");
    step(2 + ($random(gap_seed) & 7));
    training_timeout_i = 1'b1;
    step(1);
    training_timeout_i = 1'b0;
    answer_params(24'h00_2000, 0);
    wait_for(1, "cl0_o after retraining");

    bring_up(32'h0000_0040, 24'h00_2000, 0);
    wait_for(2, "training_o");
    step(5);
    lane_disable_i = 1'b1;                       // disable mid training
    step(1);
    lane_disable_i = 1'b0;
    step(5);

    $display("checks=%0d errors=%0d testbench failures=%0d", chk_cnt, err_cnt, tb_fail);
    if (err_cnt == 0 && tb_fail == 0)
      $display("STATUS: PASS");
    else
      $display("STATUS: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

// ==== verilog/cable_prop_reader.sv ====
`include "lane_init_defs.svh"

`default_nettype none

module cable_prop_reader
  import lane_init_pkg::*;
(
  input  wire                        fsm_clk,
  input  wire                        reset_n,
  input  wire lane_state_e           state_i,
  input  wire [`LI_CFG_DATA_W-1:0]   cfg_data_i,
  output logic                       cfg_rd_o,
  output logic [`LI_CFG_ADDR_W-1:0]  cfg_addr_o,
  output logic                       usb4_ok_o,
  output link_gen_e                  cable_gen_o
);

  logic in_prop;
  logic rd_issued;    // strobe already sent during this visit

  assign in_prop    = (state_i == CLD_CABLE_PROP);
  assign cfg_rd_o   = in_prop && !rd_issued;    // first cycle only
  assign cfg_addr_o = cfg_rd_o ? `LI_CABLE_PROP_ADDR : '0;

  always_ff @(posedge fsm_clk or negedge reset_n)
  begin
    if (!reset_n)
      rd_issued <= 1'b0;
    else
      rd_issued <= in_prop;
  end

  // read data is valid from the cycle after the strobe
  always_ff @(posedge fsm_clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      usb4_ok_o   <= 1'b0;
      cable_gen_o <= GEN4;
    end
    else if (state_i == DISABLED)
    begin
      usb4_ok_o   <= 1'b0;
      cable_gen_o <= GEN4;
    end
    else if (in_prop && rd_issued)
    begin
      usb4_ok_o <= (cfg_data_i[7:0] == `LI_USB4_ID);
      if (cfg_data_i[`LI_CABLE_G4_BIT])
        cable_gen_o <= GEN4;
      else if (cfg_data_i[`LI_CABLE_G3_BIT])
        cable_gen_o <= GEN3;
      else
        cable_gen_o <= GEN2;   // legacy cable
    end
  end

endmodule

`default_nettype wire

// ==== verilog/lane_init_defs.svh ====
`ifndef LANE_INIT_DEFS_SVH
`define LANE_INIT_DEFS_SVH

// bus and counter widths
`define LI_CFG_DATA_W       32
`define LI_CFG_ADDR_W       8
`define LI_PAYLOAD_W        24
`define LI_SENT_CNT_W       6
`define LI_RECV_CNT_W       2

// cable property word in configuration space
`define LI_CABLE_PROP_ADDR  8'd18
`define LI_USB4_ID          8'h40
`define LI_CABLE_G4_BIT     21
`define LI_CABLE_G3_BIT     20

// partner generation bits in the AT response payload
`define LI_PEER_G4_BIT      18
`define LI_PEER_G3_BIT      13

// ordered sets sent and received per training phase
`define LI_G4_SENT          6'd16
`define LI_G4_RECV          2'd1
`define LI_SLOS_SENT        6'd2
`define LI_G23_RECV         2'd2
`define LI_G3_TS1_SENT      6'd16
`define LI_G2_TS1_SENT      6'd32
`define LI_G3_TS2_SENT      6'd8
`define LI_G2_TS2_SENT      6'd16

`endif

// ==== verilog/lane_init_fsm.sv ====
`default_nettype none

module lane_init_fsm
  import lane_init_pkg::*;
(
  input  wire               fsm_clk,
  input  wire               reset_n,
  input  wire               lane_disable_i,
  input  wire               disabled_min_i,
  input  wire               disconnect_rx_i,
  input  wire               training_timeout_i,
  input  wire               new_sym_i,
  input  wire               usb4_ok_i,
  input  wire               params_done_i,
  input  wire               phase_done_i,
  input  wire link_gen_e    gen_i,
  output lane_state_e       state_o,
  output os_sel_e           os_sel_o,
  output logic              disabled_o,
  output logic              training_o,
  output logic              cl0_o,
  output logic              sbtx_idle_o
);

  lane_state_e state_q;
  lane_state_e state_d;
  logic        in_training;

  assign in_training = (state_q >= TRAINING_G4_TS1) && (state_q <= TRAINING_G23_TS2);

  always_ff @(posedge fsm_clk or negedge reset_n)
  begin
    if (!reset_n)
      state_q <= DISABLED;
    else
      state_q <= state_d;
  end

  ////////////////////////// next-state logic ////////////////////////////////

  always_comb
  begin
    state_d = state_q;
    case (state_q)
      DISABLED:
        if (disabled_min_i)
          state_d = CLD_CABLE_PROP;    // minimum disabled time elapsed
      CLD_CABLE_PROP:
        if (usb4_ok_i)
          state_d = CLD_DET_DEVICE;
      CLD_DET_DEVICE:
        if (!disconnect_rx_i)
          state_d = CLD_PARAMETERS_1;  // far device present
      CLD_PARAMETERS_1:
        if (params_done_i)
          state_d = CLD_PARAMETERS_2;
      CLD_PARAMETERS_2:
        state_d = CLD_CLK_SWITCH;
      CLD_CLK_SWITCH:
        if (new_sym_i)
          state_d = (gen_i == GEN4) ? TRAINING_G4_TS1 : TRAINING_G23_SLOS1;
      TRAINING_G4_TS1:
        if (phase_done_i)
          state_d = TRAINING_G4_TS2;
      TRAINING_G4_TS2:
        if (phase_done_i)
          state_d = TRAINING_G4_TS3;
      TRAINING_G4_TS3:
        if (phase_done_i)
          state_d = TRAINING_G4_TS4;
      TRAINING_G4_TS4:
        if (phase_done_i && new_sym_i)
          state_d = CL0;
      TRAINING_G23_SLOS1:
        if (phase_done_i)
          state_d = TRAINING_G23_SLOS2;
      TRAINING_G23_SLOS2:
        if (phase_done_i && new_sym_i)
          state_d = TRAINING_G23_TS1;
      TRAINING_G23_TS1:
        if (phase_done_i && new_sym_i)
          state_d = TRAINING_G23_TS2;
      TRAINING_G23_TS2:
        if (phase_done_i && new_sym_i)
          state_d = CL0;
      CL0:
        state_d = CL0;                 // stays until disconnect or disable
      default:
        state_d = DISABLED;
    endcase

    // exits shared by groups of states, later ones win
    if (in_training && training_timeout_i)
      state_d = CLD_PARAMETERS_1;      // retrain from parameter exchange
    if (state_q >= CLD_PARAMETERS_1 && disconnect_rx_i)
      state_d = CLD_DET_DEVICE;
    if (lane_disable_i)
      state_d = DISABLED;
  end

  ////////////////////////// state decode ////////////////////////////////////

  assign state_o     = state_q;
  assign os_sel_o    = os_for_state(state_q);
  assign disabled_o  = (state_q == DISABLED);
  assign training_o  = in_training;
  assign cl0_o       = (state_q == CL0);
  assign sbtx_idle_o = (state_q == DISABLED) || (state_q == CLD_CABLE_PROP);

  // link is never reported as training and up at once
  assert property (@(posedge fsm_clk) disable iff (!reset_n)
    !(training_o && cl0_o));

endmodule

`default_nettype wire

// ==== verilog/lane_init_pkg.sv ====
`default_nettype none

`include "lane_init_defs.svh"

package lane_init_pkg;

  typedef enum logic [3:0] {
    DISABLED           = 4'd0,
    CLD_CABLE_PROP     = 4'd1,
    CLD_DET_DEVICE     = 4'd2,
    CLD_PARAMETERS_1   = 4'd3,
    CLD_PARAMETERS_2   = 4'd4,
    CLD_CLK_SWITCH     = 4'd5,
    TRAINING_G4_TS1    = 4'd6,
    TRAINING_G4_TS2    = 4'd7,
    TRAINING_G4_TS3    = 4'd8,
    TRAINING_G4_TS4    = 4'd9,
    TRAINING_G23_SLOS1 = 4'd10,
    TRAINING_G23_SLOS2 = 4'd11,
    TRAINING_G23_TS1   = 4'd12,
    TRAINING_G23_TS2   = 4'd13,
    CL0                = 4'd14
  } lane_state_e;

  typedef enum logic [3:0] {
    OS_SLOS1   = 4'd0,
    OS_SLOS2   = 4'd1,
    OS_G23_TS1 = 4'd2,
    OS_G23_TS2 = 4'd3,
    OS_G4_TS1  = 4'd4,
    OS_G4_TS2  = 4'd5,
    OS_G4_TS3  = 4'd6,
    OS_G4_TS4  = 4'd7,
    OS_DATA    = 4'd8,   // transport layer data
    OS_ZEROS   = 4'd9
  } os_sel_e;

  typedef enum logic [1:0] {
    GEN4 = 2'd0,
    GEN3 = 2'd1,
    GEN2 = 2'd2
  } link_gen_e;

  typedef struct packed {
    os_sel_e lane0;
    os_sel_e lane1;
  } os_rx_t;

  typedef struct packed {
    logic                     valid;
    logic                     error;
    logic [`LI_PAYLOAD_W-1:0] payload;
  } at_rsp_t;

  // ordered set carried on the lanes in each state
  function automatic os_sel_e os_for_state(lane_state_e s);
    os_sel_e os;
    case (s)
      TRAINING_G4_TS1:    os = OS_G4_TS1;
      TRAINING_G4_TS2:    os = OS_G4_TS2;
      TRAINING_G4_TS3:    os = OS_G4_TS3;
      TRAINING_G4_TS4:    os = OS_G4_TS4;
      TRAINING_G23_SLOS1: os = OS_SLOS1;
      TRAINING_G23_SLOS2: os = OS_SLOS2;
      TRAINING_G23_TS1:   os = OS_G23_TS1;
      TRAINING_G23_TS2:   os = OS_G23_TS2;
      CL0:                os = OS_DATA;
      default:            os = OS_ZEROS;
    endcase
    return os;
  endfunction

endpackage

`default_nettype wire

// ==== verilog/lane_init_top.sv ====
`include "lane_init_defs.svh"

`default_nettype none

module lane_init_top
  import lane_init_pkg::*;
(
  input  wire                        fsm_clk,
  input  wire                        reset_n,
  input  wire                        lane_disable_i,
  input  wire                        disabled_min_i,
  input  wire                        disconnect_rx_i,
  input  wire                        training_timeout_i,
  input  wire                        new_sym_i,
  input  wire                        os_sent_i,
  input  wire os_rx_t                os_rx_i,
  input  wire at_rsp_t               at_rsp_i,
  input  wire                        sync_busy_i,
  input  wire [`LI_CFG_DATA_W-1:0]   cfg_data_i,
  output wire os_sel_e               os_sel_o,
  output wire link_gen_e             gen_speed_o,
  output wire                        disabled_o,
  output wire                        training_o,
  output wire                        cl0_o,
  output wire                        sbtx_idle_o,
  output wire                        at_req_o,
  output wire                        cfg_rd_o,
  output wire [`LI_CFG_ADDR_W-1:0]   cfg_addr_o
);

  lane_state_e fsm_state;
  link_gen_e   cable_gen;
  logic        usb4_ok;
  logic        params_done;
  logic        phase_done;

  cable_prop_reader u_cable_prop_reader (
    .fsm_clk     (fsm_clk),
    .reset_n     (reset_n),
    .state_i     (fsm_state),
    .cfg_data_i  (cfg_data_i),
    .cfg_rd_o    (cfg_rd_o),
    .cfg_addr_o  (cfg_addr_o),
    .usb4_ok_o   (usb4_ok),
    .cable_gen_o (cable_gen)
  );

  param_exchange u_param_exchange (
    .fsm_clk       (fsm_clk),
    .reset_n       (reset_n),
    .state_i       (fsm_state),
    .at_rsp_i      (at_rsp_i),
    .sync_busy_i   (sync_busy_i),
    .cable_gen_i   (cable_gen),
    .at_req_o      (at_req_o),
    .params_done_o (params_done),
    .gen_speed_o   (gen_speed_o)     // negotiated link generation
  );

  os_counter u_os_counter (
    .fsm_clk      (fsm_clk),
    .reset_n      (reset_n),
    .state_i      (fsm_state),
    .gen_i        (gen_speed_o),
    .os_sent_i    (os_sent_i),
    .os_rx_i      (os_rx_i),
    .phase_done_o (phase_done)
  );

  lane_init_fsm u_lane_init_fsm (
    .fsm_clk            (fsm_clk),
    .reset_n            (reset_n),
    .lane_disable_i     (lane_disable_i),
    .disabled_min_i     (disabled_min_i),
    .disconnect_rx_i    (disconnect_rx_i),
    .training_timeout_i (training_timeout_i),
    .new_sym_i          (new_sym_i),
    .usb4_ok_i          (usb4_ok),
    .params_done_i      (params_done),
    .phase_done_i       (phase_done),
    .gen_i              (gen_speed_o),
    .state_o            (fsm_state),
    .os_sel_o           (os_sel_o),
    .disabled_o         (disabled_o),
    .training_o         (training_o),
    .cl0_o              (cl0_o),
    .sbtx_idle_o        (sbtx_idle_o)
  );

endmodule

`default_nettype wire

// ==== verilog/os_counter.sv ====
`include "lane_init_defs.svh"

`default_nettype none

module os_counter
  import lane_init_pkg::*;
(
  input  wire               fsm_clk,
  input  wire               reset_n,
  input  wire lane_state_e  state_i,
  input  wire link_gen_e    gen_i,
  input  wire               os_sent_i,
  input  wire os_rx_t       os_rx_i,
  output logic              phase_done_o
);

  lane_state_e               prev_state;
  os_sel_e                   exp_os;
  logic                      training;
  logic                      changed;
  logic [`LI_SENT_CNT_W-1:0] sent_tgt;
  logic [`LI_SENT_CNT_W-1:0] sent_cnt;
  logic [`LI_RECV_CNT_W-1:0] recv_tgt;
  logic [`LI_RECV_CNT_W-1:0] rx0_cnt;
  logic [`LI_RECV_CNT_W-1:0] rx1_cnt;

  ////////////////////////// phase targets ///////////////////////////////////

  assign exp_os  = os_for_state(state_i);
  assign changed = (state_i != prev_state);

  always_comb
  begin
    training = 1'b1;
    sent_tgt = '0;
    recv_tgt = '0;
    case (state_i)
      TRAINING_G4_TS1, TRAINING_G4_TS2, TRAINING_G4_TS3, TRAINING_G4_TS4:
      begin
        sent_tgt = `LI_G4_SENT;
        recv_tgt = `LI_G4_RECV;
      end
      TRAINING_G23_SLOS1, TRAINING_G23_SLOS2:
      begin
        sent_tgt = `LI_SLOS_SENT;
        recv_tgt = `LI_G23_RECV;
      end
      TRAINING_G23_TS1:
      begin
        sent_tgt = (gen_i == GEN2) ? `LI_G2_TS1_SENT : `LI_G3_TS1_SENT;
        recv_tgt = `LI_G23_RECV;
      end
      TRAINING_G23_TS2:
      begin
        sent_tgt = (gen_i == GEN2) ? `LI_G2_TS2_SENT : `LI_G3_TS2_SENT;
        recv_tgt = `LI_G23_RECV;
      end
      default: training = 1'b0;
    endcase
  end

  ////////////////////////// saturating counters /////////////////////////////

  always_ff @(posedge fsm_clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      prev_state <= DISABLED;
      sent_cnt   <= '0;
      rx0_cnt    <= '0;
      rx1_cnt    <= '0;
    end
    else
    begin
      prev_state <= state_i;
      if (!training || changed)
      begin
        sent_cnt <= '0;   // fresh start for every phase
        rx0_cnt  <= '0;
        rx1_cnt  <= '0;
      end
      else
      begin
        if (os_sent_i && sent_cnt < sent_tgt)
          sent_cnt <= sent_cnt + 1'b1;
        if (os_rx_i.lane0 == exp_os && rx0_cnt < recv_tgt)
          rx0_cnt <= rx0_cnt + 1'b1;
        if (os_rx_i.lane1 == exp_os && rx1_cnt < recv_tgt)
          rx1_cnt <= rx1_cnt + 1'b1;
      end
    end
  end

  // counts left over from the previous phase are masked on its first cycle
  assign phase_done_o = training && !changed && (sent_cnt == sent_tgt) &&
                        (rx0_cnt == recv_tgt) && (rx1_cnt == recv_tgt);

  // once a phase has settled its counts never pass the phase targets
  assert property (@(posedge fsm_clk) disable iff (!reset_n)
    (training && !changed) |->
      (sent_cnt <= sent_tgt && rx0_cnt <= recv_tgt && rx1_cnt <= recv_tgt));

endmodule

`default_nettype wire

// ==== verilog/param_exchange.sv ====
`include "lane_init_defs.svh"

`default_nettype none

module param_exchange
  import lane_init_pkg::*;
(
  input  wire                fsm_clk,
  input  wire                reset_n,
  input  wire lane_state_e   state_i,
  input  wire at_rsp_t       at_rsp_i,
  input  wire                sync_busy_i,
  input  wire link_gen_e     cable_gen_i,
  output logic               at_req_o,
  output logic               params_done_o,
  output link_gen_e          gen_speed_o
);

  lane_state_e prev_state;
  logic        in_params;
  logic        rsp_ok;
  logic        rsp_err;
  logic        req_pend;     // request waiting for the synchronizer
  link_gen_e   peer_gen;
  link_gen_e   link_gen;

  assign in_params = (state_i == CLD_PARAMETERS_1);
  assign rsp_ok    = in_params && at_rsp_i.valid && !at_rsp_i.error;
  assign rsp_err   = in_params && at_rsp_i.valid && at_rsp_i.error;
  assign at_req_o  = req_pend && !sync_busy_i;

  always_comb
  begin
    if (at_rsp_i.payload[`LI_PEER_G4_BIT])
      peer_gen = GEN4;
    else if (at_rsp_i.payload[`LI_PEER_G3_BIT])
      peer_gen = GEN3;
    else
      peer_gen = GEN2;
  end

  // larger encoding is the slower generation
  assign link_gen = (peer_gen > cable_gen_i) ? peer_gen : cable_gen_i;

  always_ff @(posedge fsm_clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      prev_state    <= DISABLED;
      req_pend      <= 1'b0;
      params_done_o <= 1'b0;
      gen_speed_o   <= GEN4;
    end
    else
    begin
      prev_state    <= state_i;
      params_done_o <= rsp_ok;

      if (!in_params)
        req_pend <= 1'b0;
      else if (prev_state != CLD_PARAMETERS_1 || rsp_err)
        req_pend <= 1'b1;    // entry or retry
      else if (at_req_o)
        req_pend <= 1'b0;

      if (state_i == DISABLED)
        gen_speed_o <= GEN4;
      else if (rsp_ok)
        gen_speed_o <= link_gen;
    end
  end

  // a request held back by the synchronizer stays pending
  assert property (@(posedge fsm_clk) disable iff (!reset_n)
    (in_params && req_pend && sync_busy_i) |=> req_pend);

endmodule

`default_nettype wire
